// ==== hdl/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    // geometry
    localparam int ADDR_W     = 32;
    localparam int WORD_W     = 32;
    localparam int LINE_WORDS = 4;
    localparam int LINE_BYTES = 16;
    localparam int OFFSET_W   = 4;
    localparam int INDEX_W    = 4;    // 16 sets
    localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;
    localparam int WAYS       = 2;
    localparam int BEAT_W     = 2;

    // request size codes
    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam logic [1:0] SIZE_WORD = 2'd2;

    // controller states
    localparam logic [2:0] ST_IDLE    = 3'd0;
    localparam logic [2:0] ST_LOOKUP  = 3'd1;
    localparam logic [2:0] ST_WB_SEND = 3'd2;
    localparam logic [2:0] ST_RF_REQ  = 3'd3;
    localparam logic [2:0] ST_RF_DATA = 3'd4;
    localparam logic [2:0] ST_FILL    = 3'd5;

    // one cache line, seen as words (beats, loads) or as bytes (store merge)
    typedef union packed {
        logic [LINE_WORDS-1:0][WORD_W-1:0] words;
        logic [LINE_BYTES-1:0][7:0]        bytes;
    } line_u;

endpackage

`default_nettype wire

// ==== hdl/beat_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module beat_counter
    import dcache_pkg::*;
(
    input  wire               clk,
    input  wire               rstn,
    input  wire               i_step,
    output logic [BEAT_W-1:0] o_beat,
    output logic              o_last
);
    always_ff @(posedge clk) begin
        if (!rstn)
            o_beat <= '0;
        else if (i_step)
            o_beat <= o_beat + 1'b1;    // wraps to zero after the last beat
    end

    assign o_last = (o_beat == BEAT_W'(LINE_WORDS - 1));

    // bursts never chain back to back, there is always a gap after the last beat
    a_no_chain: assert property (@(posedge clk) disable iff (!rstn)
        i_step && o_last |=> !i_step);

endmodule

`default_nettype wire

// ==== hdl/way_arrays.sv ====
`timescale 1ns/1ps
`default_nettype none

module way_arrays
    import dcache_pkg::*;
(
    input  wire                   clk,
    input  wire                   rstn,
    input  wire [INDEX_W-1:0]     i_rd_index,
    input  wire [TAG_W-1:0]       i_tag,
    input  wire                   i_store_we,
    input  wire [LINE_BYTES-1:0]  i_byte_en,
    input  wire line_u            i_store_line,
    input  wire                   i_fill_we,
    input  wire line_u            i_fill_line,
    input  wire                   i_fill_dirty,
    input  wire                   i_lru_touch,
    output logic                  o_hit,
    output line_u                 o_hit_line,
    output logic                  o_victim_dirty,
    output logic [TAG_W-1:0]      o_victim_tag,
    output line_u                 o_victim_line
);
    line_u                 data_mem [WAYS][2**INDEX_W];
    logic [TAG_W-1:0]      tag_mem  [WAYS][2**INDEX_W];
    logic [2**INDEX_W-1:0] valid_q  [WAYS];
    logic [2**INDEX_W-1:0] dirty_q  [WAYS];
    logic [2**INDEX_W-1:0] lru_q;    // way to replace next, per set

    logic [INDEX_W-1:0]    idx_q;
    logic [TAG_W-1:0]      tag_rd  [WAYS];
    line_u                 line_rd [WAYS];
    logic [WAYS-1:0]       hit_w;
    logic                  hit_way, victim_way;

    // read one cycle after the index, writes use the index being looked up
    always_ff @(posedge clk) begin
        idx_q <= i_rd_index;
        for (int w = 0; w < WAYS; w++) begin
            tag_rd[w]  <= tag_mem[w][i_rd_index];
            line_rd[w] <= data_mem[w][i_rd_index];
        end
        if (i_store_we) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (i_byte_en[b])
                    data_mem[hit_way][idx_q].bytes[b] <= i_store_line.bytes[b];
            end
        end
        if (i_fill_we) begin
            data_mem[victim_way][idx_q] <= i_fill_line;
            tag_mem[victim_way][idx_q]  <= i_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '{default: '0};
            dirty_q <= '{default: '0};
            lru_q   <= '0;
        end else begin
            if (i_store_we)
                dirty_q[hit_way][idx_q] <= 1'b1;
            if (i_fill_we) begin
                valid_q[victim_way][idx_q] <= 1'b1;
                dirty_q[victim_way][idx_q] <= i_fill_dirty;
                lru_q[idx_q]               <= ~victim_way;
            end else if (i_lru_touch) begin
                lru_q[idx_q] <= ~hit_way;
            end
        end
    end

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            hit_w[w] = valid_q[w][idx_q] && (tag_rd[w] == i_tag);
        end
    end

    assign hit_way    = hit_w[1];
    assign victim_way = lru_q[idx_q];

    assign o_hit          = |hit_w;
    assign o_hit_line     = line_rd[hit_way];
    assign o_victim_dirty = dirty_q[victim_way][idx_q];
    assign o_victim_tag   = tag_rd[victim_way];
    assign o_victim_line  = line_rd[victim_way];

    // refill only happens for a line not already in the set
    a_fill_miss: assert property (@(posedge clk) disable iff (!rstn)
        i_fill_we |-> !o_hit);

endmodule

`default_nettype wire

// ==== hdl/line_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_buffer
    import dcache_pkg::*;
(
    input  wire               clk,
    input  wire               rstn,
    input  wire               i_capture,
    input  wire line_u        i_victim_line,
    input  wire               i_beat_we,
    input  wire [BEAT_W-1:0]  i_beat,
    input  wire [WORD_W-1:0]  i_beat_data,
    output line_u             o_line,
    output logic [WORD_W-1:0] o_beat_data
);
    // victim line first, then refill words land over it one by one
    always_ff @(posedge clk) begin
        if (!rstn)
            o_line <= '0;
        else if (i_capture)
            o_line <= i_victim_line;
        else if (i_beat_we)
            o_line.words[i_beat] <= i_beat_data;
    end

    assign o_beat_data = o_line.words[i_beat];    // write-back beat

endmodule

`default_nettype wire

// ==== hdl/load_store_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_store_align
    import dcache_pkg::*;
(
    input  wire [OFFSET_W-1:0]    i_addr_offset,
    input  wire [1:0]             i_size,
    input  wire                   i_signed,
    input  wire [WORD_W-1:0]      i_wdata,
    input  wire                   i_write,
    input  wire line_u            i_hit_line,
    input  wire line_u            i_buf_line,
    input  wire                   i_from_buffer,
    output logic [WORD_W-1:0]     o_rdata,
    output logic [LINE_BYTES-1:0] o_byte_en,
    output line_u                 o_merged_line
);
    line_u             src_line, lane_line;
    logic [WORD_W-1:0] word, lanes;
    logic [7:0]        ld_byte;
    logic [15:0]       ld_half;
    logic [3:0]        word_en;
    logic [1:0]        lane;

    assign lane     = i_addr_offset[1:0];
    assign src_line = i_from_buffer ? i_buf_line : i_hit_line;
    assign word     = src_line.words[i_addr_offset[OFFSET_W-1:2]];
    assign ld_byte  = word[{lane, 3'b000} +: 8];
    assign ld_half  = lane[1] ? word[31:16] : word[15:0];

    always_comb begin
        case (i_size)
            SIZE_BYTE: o_rdata = {{24{i_signed & ld_byte[7]}}, ld_byte};
            SIZE_HALF: o_rdata = {{16{i_signed & ld_half[15]}}, ld_half};
            default:   o_rdata = word;
        endcase
        if (i_write)
            o_rdata = '0;
    end

    always_comb begin
        case (i_size)
            SIZE_BYTE: begin
                lanes   = {4{i_wdata[7:0]}};
                word_en = 4'b0001 << lane;
            end
            SIZE_HALF: begin
                lanes   = {2{i_wdata[15:0]}};
                word_en = 4'b0011 << lane;
            end
            default: begin
                lanes   = i_wdata;
                word_en = 4'b1111;
            end
        endcase
        lane_line.words = {LINE_WORDS{lanes}};
        o_byte_en = i_write ? LINE_BYTES'(word_en) << {i_addr_offset[OFFSET_W-1:2], 2'b00} : '0;
        for (int b = 0; b < LINE_BYTES; b++) begin
            o_merged_line.bytes[b] = o_byte_en[b] ? lane_line.bytes[b] : i_buf_line.bytes[b];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/dcache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl
    import dcache_pkg::*;
(
    input  wire                clk,
    input  wire                rstn,
    input  wire                i_req_valid,
    input  wire                i_req_write,
    input  wire [1:0]          i_req_size,
    input  wire                i_req_signed,
    input  wire [ADDR_W-1:0]   i_req_addr,
    input  wire [WORD_W-1:0]   i_req_wdata,
    input  wire                i_hit,
    input  wire                i_victim_dirty,
    input  wire [TAG_W-1:0]    i_victim_tag,
    input  wire                i_beat_last,
    input  wire                i_mem_rd_ready,
    input  wire                i_mem_rdata_valid,
    input  wire                i_mem_wr_ready,
    output logic               o_req_ready,
    output logic               o_resp_valid,
    output logic [INDEX_W-1:0] o_rd_index,
    output logic [ADDR_W-1:0]  o_cur_addr,
    output logic [1:0]         o_cur_size,
    output logic               o_cur_signed,
    output logic [WORD_W-1:0]  o_cur_wdata,
    output logic               o_cur_write,
    output logic               o_store_we,
    output logic               o_fill_we,
    output logic               o_lru_touch,
    output logic               o_capture_victim,
    output logic               o_beat_step,
    output logic               o_beat_fill,
    output logic               o_from_buffer,
    output logic               o_mem_rd_valid,
    output logic [ADDR_W-1:0]  o_mem_rd_addr,
    output logic               o_mem_wr_valid,
    output logic [ADDR_W-1:0]  o_mem_wr_addr
);
    logic [2:0] state_q, state_d;
    logic       accept, lookup_hit;

    assign lookup_hit  = (state_q == ST_LOOKUP) && i_hit;
    // a load hit may take the next request in the same cycle
    assign o_req_ready = (state_q == ST_IDLE) || (lookup_hit && !o_cur_write);
    assign accept      = i_req_valid && o_req_ready;

    always_ff @(posedge clk) begin
        if (!rstn)
            state_q <= ST_IDLE;
        else
            state_q <= state_d;
    end

    // held request
    always_ff @(posedge clk) begin
        if (accept) begin
            o_cur_addr   <= i_req_addr;
            o_cur_size   <= i_req_size;
            o_cur_signed <= i_req_signed;
            o_cur_wdata  <= i_req_wdata;
            o_cur_write  <= i_req_write;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:    if (accept) state_d = ST_LOOKUP;
            ST_LOOKUP: begin
                if (i_hit)
                    state_d = accept ? ST_LOOKUP : ST_IDLE;
                else
                    state_d = i_victim_dirty ? ST_WB_SEND : ST_RF_REQ;
            end
            ST_WB_SEND: if (i_mem_wr_ready && i_beat_last) state_d = ST_RF_REQ;
            ST_RF_REQ:  if (i_mem_rd_ready) state_d = ST_RF_DATA;
            ST_RF_DATA: if (i_mem_rdata_valid && i_beat_last) state_d = ST_FILL;
            default:    state_d = ST_IDLE;    // ST_FILL lasts one cycle
        endcase
    end

    assign o_rd_index = accept ? i_req_addr[OFFSET_W +: INDEX_W] : o_cur_addr[OFFSET_W +: INDEX_W];

    assign o_resp_valid     = lookup_hit || (state_q == ST_FILL);
    assign o_store_we       = lookup_hit && o_cur_write;
    assign o_lru_touch      = lookup_hit;
    assign o_capture_victim = (state_q == ST_LOOKUP) && !i_hit;
    assign o_fill_we        = (state_q == ST_FILL);
    assign o_from_buffer    = (state_q == ST_FILL);

    assign o_mem_wr_valid = (state_q == ST_WB_SEND);
    assign o_mem_rd_valid = (state_q == ST_RF_REQ);
    assign o_beat_fill    = (state_q == ST_RF_DATA) && i_mem_rdata_valid;
    assign o_beat_step    = (o_mem_wr_valid && i_mem_wr_ready) || o_beat_fill;

    assign o_mem_wr_addr = {i_victim_tag, o_cur_addr[OFFSET_W +: INDEX_W], {OFFSET_W{1'b0}}};
    assign o_mem_rd_addr = {o_cur_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

    a_aligned: assert property (@(posedge clk) disable iff (!rstn)
        accept |-> !(i_req_size == SIZE_WORD && i_req_addr[1:0] != 2'b00)
                && !(i_req_size == SIZE_HALF && i_req_addr[0]));

    a_rd_hold: assert property (@(posedge clk) disable iff (!rstn)
        o_mem_rd_valid && !i_mem_rd_ready |=> o_mem_rd_valid && $stable(o_mem_rd_addr));

    a_wr_hold: assert property (@(posedge clk) disable iff (!rstn)
        o_mem_wr_valid && !i_mem_wr_ready |=> o_mem_wr_valid && $stable(o_mem_wr_addr));

endmodule

`default_nettype wire

// ==== hdl/dcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_top
    import dcache_pkg::*;
(
    input  wire                clk,
    input  wire                rstn,
    // pipeline request / response
    input  wire                i_req_valid,
    input  wire                i_req_write,
    input  wire [1:0]          i_req_size,
    input  wire                i_req_signed,
    input  wire [ADDR_W-1:0]   i_req_addr,
    input  wire [WORD_W-1:0]   i_req_wdata,
    output logic               o_req_ready,
    output logic               o_resp_valid,
    output logic [WORD_W-1:0]  o_resp_rdata,
    // memory read channel
    output logic               o_mem_rd_valid,
    output logic [ADDR_W-1:0]  o_mem_rd_addr,
    input  wire                i_mem_rd_ready,
    input  wire                i_mem_rdata_valid,
    input  wire [WORD_W-1:0]   i_mem_rdata,
    // memory write channel
    output logic               o_mem_wr_valid,
    output logic [ADDR_W-1:0]  o_mem_wr_addr,
    output logic [WORD_W-1:0]  o_mem_wr_data,
    input  wire                i_mem_wr_ready
);
    logic [INDEX_W-1:0]    rd_index;
    logic [ADDR_W-1:0]     cur_addr;
    logic [1:0]            cur_size;
    logic                  cur_signed, cur_write;
    logic [WORD_W-1:0]     cur_wdata;
    logic                  store_we, fill_we, lru_touch;
    logic                  capture_victim, beat_step, beat_fill, from_buffer;
    logic                  hit, victim_dirty;
    logic [TAG_W-1:0]      victim_tag;
    logic [BEAT_W-1:0]     beat;
    logic                  beat_last;
    logic [LINE_BYTES-1:0] byte_en;
    line_u                 hit_line, victim_line, buf_line, merged_line;

    dcache_ctrl dcache_ctrl_i (
        .clk, .rstn,
        .i_req_valid, .i_req_write, .i_req_size, .i_req_signed, .i_req_addr, .i_req_wdata,
        .i_hit(hit), .i_victim_dirty(victim_dirty), .i_victim_tag(victim_tag),
        .i_beat_last(beat_last),
        .i_mem_rd_ready, .i_mem_rdata_valid, .i_mem_wr_ready,
        .o_req_ready, .o_resp_valid,
        .o_rd_index(rd_index),
        .o_cur_addr(cur_addr), .o_cur_size(cur_size), .o_cur_signed(cur_signed),
        .o_cur_wdata(cur_wdata), .o_cur_write(cur_write),
        .o_store_we(store_we), .o_fill_we(fill_we), .o_lru_touch(lru_touch),
        .o_capture_victim(capture_victim), .o_beat_step(beat_step),
        .o_beat_fill(beat_fill), .o_from_buffer(from_buffer),
        .o_mem_rd_valid, .o_mem_rd_addr, .o_mem_wr_valid, .o_mem_wr_addr
    );

    beat_counter beat_counter_i (
        .clk, .rstn,
        .i_step (beat_step),
        .o_beat (beat),
        .o_last (beat_last)
    );

    way_arrays way_arrays_i (
        .clk, .rstn,
        .i_rd_index    (rd_index),
        .i_tag         (cur_addr[ADDR_W-1 -: TAG_W]),
        .i_store_we    (store_we),
        .i_byte_en     (byte_en),
        .i_store_line  (merged_line),
        .i_fill_we     (fill_we),
        .i_fill_line   (merged_line),
        .i_fill_dirty  (cur_write),    // a store miss leaves the line dirty
        .i_lru_touch   (lru_touch),
        .o_hit         (hit),
        .o_hit_line    (hit_line),
        .o_victim_dirty(victim_dirty),
        .o_victim_tag  (victim_tag),
        .o_victim_line (victim_line)
    );

    line_buffer line_buffer_i (
        .clk, .rstn,
        .i_capture    (capture_victim),
        .i_victim_line(victim_line),
        .i_beat_we    (beat_fill),
        .i_beat       (beat),
        .i_beat_data  (i_mem_rdata),
        .o_line       (buf_line),
        .o_beat_data  (o_mem_wr_data)
    );

    load_store_align load_store_align_i (
        .i_addr_offset(cur_addr[OFFSET_W-1:0]),
        .i_size       (cur_size),
        .i_signed     (cur_signed),
        .i_wdata      (cur_wdata),
        .i_write      (cur_write),
        .i_hit_line   (hit_line),
        .i_buf_line   (buf_line),
        .i_from_buffer(from_buffer),
        .o_rdata      (o_resp_rdata),
        .o_byte_en    (byte_en),
        .o_merged_line(merged_line)
    );

endmodule

`default_nettype wire

// ==== verification/tb_dcache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dcache
    import dcache_pkg::*;
();
    localparam int MEM_WORDS      = 4096;
    localparam int CYCLES_PER_REQ = 400;

    logic              clk;
    logic              rstn;
    logic              i_req_valid;
    logic              i_req_write;
    logic [1:0]        i_req_size;
    logic              i_req_signed;
    logic [ADDR_W-1:0] i_req_addr;
    logic [WORD_W-1:0] i_req_wdata;
    logic              o_req_ready;
    logic              o_resp_valid;
    logic [WORD_W-1:0] o_resp_rdata;
    logic              o_mem_rd_valid;
    logic [ADDR_W-1:0] o_mem_rd_addr;
    logic              i_mem_rd_ready;
    logic              i_mem_rdata_valid;
    logic [WORD_W-1:0] i_mem_rdata;
    logic              o_mem_wr_valid;
    logic [ADDR_W-1:0] o_mem_wr_addr;
    logic [WORD_W-1:0] o_mem_wr_data;
    logic              i_mem_wr_ready;

    logic [WORD_W-1:0] mem     [MEM_WORDS];    // backing memory
    logic [WORD_W-1:0] ref_mem [MEM_WORDS];    // expected contents after every store
    bit                stored_lines [int unsigned];

    logic              tv_write  [$];
    logic [1:0]        tv_size   [$];
    logic              tv_signed [$];
    logic [ADDR_W-1:0] tv_addr   [$];
    logic [WORD_W-1:0] tv_wdata  [$];
    logic [WORD_W-1:0] tv_exp    [$];

    logic [WORD_W-1:0] exp_q  [$];    // accepted requests, oldest first
    string             name_q [$];

    int                cycle_count;
    int                cycle_limit;
    int                resp_count;
    int                wb_bursts;
    logic [31:0]       rd_rng;
    logic [31:0]       wr_rng;

    dcache_top dcache_top_i (
        .clk              (clk),
        .rstn             (rstn),
        .i_req_valid      (i_req_valid),
        .i_req_write      (i_req_write),
        .i_req_size       (i_req_size),
        .i_req_signed     (i_req_signed),
        .i_req_addr       (i_req_addr),
        .i_req_wdata      (i_req_wdata),
        .o_req_ready      (o_req_ready),
        .o_resp_valid     (o_resp_valid),
        .o_resp_rdata     (o_resp_rdata),
        .o_mem_rd_valid   (o_mem_rd_valid),
        .o_mem_rd_addr    (o_mem_rd_addr),
        .i_mem_rd_ready   (i_mem_rd_ready),
        .i_mem_rdata_valid(i_mem_rdata_valid),
        .i_mem_rdata      (i_mem_rdata),
        .o_mem_wr_valid   (o_mem_wr_valid),
        .o_mem_wr_addr    (o_mem_wr_addr),
        .o_mem_wr_data    (o_mem_wr_data),
        .i_mem_wr_ready   (i_mem_wr_ready)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic string state_name(input logic [2:0] s);
        case (s)
            ST_IDLE:    return "IDLE";
            ST_LOOKUP:  return "LOOKUP";
            ST_WB_SEND: return "WB_SEND";
            ST_RF_REQ:  return "RF_REQ";
            ST_RF_DATA: return "RF_DATA";
            ST_FILL:    return "FILL";
            default:    return "unknown";
        endcase
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected)
            fail_run($sformatf("[FAIL] %s: expected %08h, actual %08h", name, expected, actual));
    endtask

    // byte lanes of the store land in the expected memory image
    task automatic update_reference(input logic [ADDR_W-1:0] addr, input logic [1:0] size,
                                    input logic [WORD_W-1:0] wdata);
        int unsigned w;
        w = addr >> 2;
        case (size)
            SIZE_BYTE: ref_mem[w][8*addr[1:0] +: 8]  = wdata[7:0];
            SIZE_HALF: ref_mem[w][8*addr[1:0] +: 16] = wdata[15:0];
            default:   ref_mem[w] = wdata;
        endcase
        stored_lines[addr >> OFFSET_W] = 1'b1;
    endtask

    task automatic load_vectors();
        int                fd;
        int                n;
        string             text;
        logic              w, sg;
        logic [1:0]        sz;
        logic [ADDR_W-1:0] a;
        logic [WORD_W-1:0] wd, e;
        fd = $fopen("verification/dcache_testdata.txt", "r");
        if (fd == 0)
            fail_run("could not open verification/dcache_testdata.txt");
        while ($fgets(text, fd) != 0) begin
            if (text.len() < 2 || text.substr(0, 0) == "#")
                continue;    // blank or comment
            n = $sscanf(text, "%h %h %h %h %h %h", w, sz, sg, a, wd, e);
            if (n != 6)
                fail_run({"malformed line in data file: ", text});
            if (a >= MEM_WORDS * 4)
                fail_run("data file address lies outside the memory model");
            tv_write.push_back(w);
            tv_size.push_back(sz);
            tv_signed.push_back(sg);
            tv_addr.push_back(a);
            tv_wdata.push_back(wd);
            tv_exp.push_back(e);
        end
        $fclose(fd);
        if (tv_addr.size() == 0)
            fail_run("data file holds no requests");
    endtask

    // one request at a time, held until the cache takes it
    task automatic run_requests();
        bit taken;
        for (int i = 0; i < tv_addr.size(); i++) begin
            i_req_valid  = 1'b1;
            i_req_write  = tv_write[i];
            i_req_size   = tv_size[i];
            i_req_signed = tv_signed[i];
            i_req_addr   = tv_addr[i];
            i_req_wdata  = tv_wdata[i];
            taken = 1'b0;
            while (!taken) begin
                @(negedge clk);
                if (o_req_ready === 1'b1) begin    // transfers at the coming edge
                    taken = 1'b1;
                    exp_q.push_back(tv_exp[i]);
                    name_q.push_back($sformatf("request %0d at %08h", i + 1, tv_addr[i]));
                    if (tv_write[i])
                        update_reference(tv_addr[i], tv_size[i], tv_wdata[i]);
                end
                @(posedge clk);
                #1;
            end
        end
        i_req_valid = 1'b0;
    endtask

    always @(negedge clk) begin : response_monitor
        if (rstn && o_resp_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                fail_run("response arrived with no request outstanding");
            end else begin
                compare_value(name_q.pop_front(), exp_q.pop_front(), o_resp_rdata);
                resp_count++;
            end
        end
    end

    initial begin : read_memory_model
        logic [ADDR_W-1:0] base;
        int                gap;
        forever begin
            @(posedge clk);
            #1;
            rd_rng = xorshift32(rd_rng);
            i_mem_rdata_valid = 1'b0;
            i_mem_rd_ready    = rstn && (rd_rng[1:0] != 2'b00);
            @(negedge clk);
            if (o_mem_rd_valid === 1'b1 && i_mem_rd_ready) begin
                base = o_mem_rd_addr;
                compare_value("refill address alignment", '0, base[OFFSET_W-1:0]);
                if (base >= MEM_WORDS * 4)
                    fail_run("refill address lies outside the memory model");
                for (int b = 0; b < LINE_WORDS; b++) begin
                    rd_rng = xorshift32(rd_rng);
                    gap = rd_rng % 3;    // idle cycles before this beat
                    repeat (gap) begin
                        @(posedge clk);
                        #1;
                        i_mem_rd_ready    = 1'b0;
                        i_mem_rdata_valid = 1'b0;
                    end
                    @(posedge clk);
                    #1;
                    i_mem_rd_ready    = 1'b0;
                    i_mem_rdata_valid = 1'b1;
                    i_mem_rdata       = mem[(base >> 2) + b];
                end
            end
        end
    end

    initial begin : write_memory_model
        logic [ADDR_W-1:0] burst_addr;
        int unsigned       beat;
        int unsigned       word;
        beat = 0;
        forever begin
            @(posedge clk);
            #1;
            wr_rng = xorshift32(wr_rng);
            i_mem_wr_ready = rstn && (wr_rng[2:1] != 2'b00);
            @(negedge clk);
            if (o_mem_wr_valid === 1'b1 && i_mem_wr_ready) begin
                if (beat == 0) begin
                    burst_addr = o_mem_wr_addr;
                    compare_value("write-back address alignment", '0,
                                  burst_addr[OFFSET_W-1:0]);
                    if (burst_addr >= MEM_WORDS * 4)
                        fail_run("write-back address lies outside the memory model");
                    if (!stored_lines.exists(burst_addr >> OFFSET_W))
                        fail_run($sformatf("line %08h written back but never stored to",
                                           burst_addr));
                end
                compare_value($sformatf("write-back address, beat %0d", beat),
                              burst_addr, o_mem_wr_addr);
                word = (burst_addr >> 2) + beat;
                compare_value($sformatf("write-back %08h beat %0d", burst_addr, beat),
                              ref_mem[word], o_mem_wr_data);
                mem[word] = o_mem_wr_data;
                beat = (beat + 1) % LINE_WORDS;
                if (beat == 0)
                    wb_bursts++;
            end
        end
    end

    always @(posedge clk) begin : watchdog
        cycle_count++;
        if (cycle_limit != 0 && cycle_count > cycle_limit)
            fail_run($sformatf("timeout: run did not finish within %0d cycles, controller in %s",
                               cycle_limit, state_name(dcache_top_i.dcache_ctrl_i.state_q)));
    end

    initial begin : main
        clk               = 1'b0;
        rstn              = 1'b0;
        i_req_valid       = 1'b0;
        i_req_write       = 1'b0;
        i_req_size        = SIZE_WORD;
        i_req_signed      = 1'b0;
        i_req_addr        = '0;
        i_req_wdata       = '0;
        i_mem_rd_ready    = 1'b0;
        i_mem_rdata_valid = 1'b0;
        i_mem_rdata       = '0;
        i_mem_wr_ready    = 1'b0;
        cycle_count       = 0;
        cycle_limit       = 0;
        resp_count        = 0;
        wb_bursts         = 0;
        rd_rng            = 32'he2b0;
        wr_rng            = xorshift32(32'he2b0);    // second stream, one step ahead
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]     = i ^ 32'h5a5a_0000;
            ref_mem[i] = i ^ 32'h5a5a_0000;
        end
        load_vectors();
        cycle_limit = CYCLES_PER_REQ * tv_addr.size();

        repeat (4) @(posedge clk);
        #1;
        rstn = 1'b1;
        compare_value("valids after reset", '0, {o_resp_valid, o_mem_rd_valid, o_mem_wr_valid});

        run_requests();
        while (resp_count < tv_addr.size())
            @(posedge clk);

        if (wb_bursts == 0) begin
            fail_run("no dirty line was written back to memory");
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== dcache.f ====
hdl/dcache_pkg.sv
hdl/beat_counter.sv
hdl/way_arrays.sv
hdl/line_buffer.sv
hdl/load_store_align.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
verification/tb_dcache.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - hdl/dcache_pkg.sv
  - hdl/beat_counter.sv
  - hdl/way_arrays.sv
  - hdl/line_buffer.sv
  - hdl/load_store_align.sv
  - hdl/dcache_ctrl.sv
  - hdl/dcache_top.sv
  - target: test
    files:
      - verification/tb_dcache.sv

// ==== verification/dcache_testdata.txt ====
# columns, all hex: write size(0 byte, 1 half, 2 word) signed address wdata expected_rdata
# memory starts as (byte address >> 2) ^ 5a5a0000, stores answer with zero
0 2 0 00000100 00000000 5a5a0040
0 2 0 00000100 00000000 5a5a0040
0 0 1 00000304 00000000 ffffffc1
0 0 0 00000304 00000000 000000c1
0 0 1 00000305 00000000 00000000
0 0 1 00000306 00000000 0000005a
0 1 1 00000308 00000000 000000c2
0 1 1 0000030a 00000000 00005a5a
1 2 0 0000030c 8001f0e7 00000000
0 2 0 0000030c 00000000 8001f0e7
0 1 1 0000030e 00000000 ffff8001
0 1 0 0000030c 00000000 0000f0e7
0 0 1 0000030d 00000000 fffffff0
1 0 0 00000101 123456ab 00000000
1 1 0 00000102 0000cdef 00000000
0 2 0 00000100 00000000 cdefab40
1 1 0 00000526 00001234 00000000
0 2 0 00000524 00000000 12340149
0 2 0 00000620 00000000 5a5a0188
0 2 0 00000528 00000000 5a5a014a
0 2 0 00000720 00000000 5a5a01c8
0 2 0 00000624 00000000 5a5a0189
0 2 0 00000524 00000000 12340149
0 0 1 00000527 00000000 00000012
